/* tb.f */
design/dcache_pkg.sv
design/dcache_data_bank.sv
design/dcache_tag_array.sv
design/dcache_line_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/tb_dcache_mem.sv
test/tb_dcache.sv

/* run.sh */
#!/bin/sh
# compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -f tb.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

/* test/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 1;
  localparam int SEED       = 8;
  localparam int RAND_OPS   = 200;
  localparam int MAX_CYCLES = (RAND_OPS + 40) * 40;  // stalled dirty miss stays under 40 cycles

  logic              clk, rst;
  logic              req_valid, req_write, ready;
  logic [ADDR_W-1:0] req_addr, mem_rd_addr, mem_wr_addr, peek_addr;
  logic [DATA_W-1:0] req_wdata, rdata, mem_rd_data, mem_wr_data, peek_data;
  logic [7:0]        req_mask;
  logic              mem_rd_valid, mem_rd_ready, mem_wr_valid, mem_wr_ready;
  logic [7:0]        ref_mem [65536];  // mirrors every cpu write
  logic [ADDR_W-1:0] rd_base, wr_base;
  int                seed, rd_beats, wr_beats, traffic;
  int                cycles = 0;

  dcache_top #(.INDEX_W(DEF_INDEX_W)) u_dut (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid),
    .req_write_i    (req_write),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .req_mask_i     (req_mask),
    .ready_o        (ready),
    .rdata_o        (rdata),
    .mem_rd_valid_o (mem_rd_valid),
    .mem_rd_addr_o  (mem_rd_addr),
    .mem_rd_ready_i (mem_rd_ready),
    .mem_rd_data_i  (mem_rd_data),
    .mem_wr_valid_o (mem_wr_valid),
    .mem_wr_addr_o  (mem_wr_addr),
    .mem_wr_data_o  (mem_wr_data),
    .mem_wr_ready_i (mem_wr_ready)
  );

  tb_dcache_mem #(.SEED(SEED), .DLY(DRIVE_DLY)) u_mem (
    .clk         (clk),
    .rd_valid_i  (mem_rd_valid),
    .rd_addr_i   (mem_rd_addr),
    .rd_ready_o  (mem_rd_ready),
    .rd_data_o   (mem_rd_data),
    .wr_valid_i  (mem_wr_valid),
    .wr_addr_i   (mem_wr_addr),
    .wr_data_i   (mem_wr_data),
    .wr_ready_o  (mem_wr_ready),
    .peek_addr_i (peek_addr),
    .peek_data_o (peek_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin  // bus traffic seen by the tests
    if (mem_rd_valid || mem_wr_valid)
      traffic++;
    if (mem_rd_valid && mem_rd_ready) begin
      rd_beats++;
      rd_base = mem_rd_addr;
    end
    if (mem_wr_valid && mem_wr_ready) begin
      wr_beats++;
      wr_base = mem_wr_addr;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the cache did not finish the tests within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [63:0] ref_dw(input logic [31:0] a);
    logic [63:0] v;
    for (int i = 0; i < 8; i++)
      v[8*i +: 8] = ref_mem[int'(a[15:0]) + i];
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic access(input logic wr, input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] mask);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    req_mask  = mask;
    do begin
      @(posedge clk);
      #(DRIVE_DLY);
    end while (!ready);
    if (wr) begin
      for (int i = 0; i < 8; i++)
        if (mask[i])
          ref_mem[int'(addr[15:0]) + i] = wdata[8*i +: 8];
    end else begin
      check_eq("rdata_o", rdata, ref_dw(addr));
    end
    @(posedge clk);  // write hit lands at the end of the ready cycle
    #(DRIVE_DLY);
    req_valid = 1'b0;
  endtask

  task automatic clear_counters();
    rd_beats = 0;
    wr_beats = 0;
    traffic  = 0;
  endtask

  task automatic check_line(input logic [31:0] base);
    for (int k = 0; k < BEATS; k++) begin
      peek_addr = base + 32'(8 * k);
      #1;
      check_eq($sformatf("mem[%h]", peek_addr), peek_data, ref_dw(peek_addr));
    end
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic cold_read_miss();
    clear_counters();
    access(1'b0, 32'h0000_1048, '0, '0);
    check_eq("read beat count", 64'(rd_beats), 64'd8);
    check_eq("mem_rd_addr_o", 64'(rd_base), 64'h1040);
    check_eq("write beat count", 64'(wr_beats), 64'd0);
  endtask

  task automatic read_hit();
    clear_counters();
    access(1'b0, 32'h0000_1078, '0, '0);
    check_eq("mem_rd_valid_o cycles", 64'(traffic), 64'd0);
  endtask

  task automatic masked_write_hit();
    clear_counters();
    access(1'b1, 32'h0000_1048, 64'h1122_3344_5566_7788, 8'ha5);
    access(1'b0, 32'h0000_1048, '0, '0);
    check_eq("memory traffic cycles", 64'(traffic), 64'd0);
  endtask

  task automatic dirty_eviction();
    clear_counters();
    access(1'b0, 32'h0000_2048, '0, '0);  // same index, new tag
    check_eq("write beat count", 64'(wr_beats), 64'd8);
    check_eq("mem_wr_addr_o", 64'(wr_base), 64'h1040);
    check_eq("read beat count", 64'(rd_beats), 64'd8);
    check_eq("mem_rd_addr_o", 64'(rd_base), 64'h2040);
    check_line(32'h0000_1040);
  endtask

  task automatic random_sequence();
    logic [31:0] addr;
    logic [7:0]  mask;
    for (int n = 0; n < RAND_OPS; n++) begin
      // tags 0..3 on indexes 0..3
      addr = {18'h0, 2'($random(seed)), 4'h0, 2'($random(seed)), 3'($random(seed)), 3'b000};
      mask = 8'($random(seed));
      if (mask == 8'h00)
        mask = 8'h01;
      access(1'($random(seed)), addr, {$random(seed), $random(seed)}, mask);
    end
    for (int idx = 0; idx < 4; idx++)
      access(1'b0, 32'h8000 | 32'(idx << 6), '0, '0);  // tag 8 pushes every dirty line out
    for (int line = 0; line < 16; line++)
      check_line(32'((line / 4) << 12 | (line % 4) << 6));
  endtask

  initial begin
    logic [63:0] fill;
    seed      = SEED;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_mask  = '0;
    peek_addr = '0;
    clear_counters();
    for (int a = 0; a < 65536; a += 8) begin
      fill = {32'(a) ^ 32'ha5c3_0f00, ~32'(a)};  // same pattern the memory starts with
      for (int i = 0; i < 8; i++)
        ref_mem[a + i] = fill[8*i +: 8];
    end
    repeat (5) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;
    cold_read_miss();
    read_hit();
    masked_write_hit();
    dirty_eviction();
    random_sequence();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_dcache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_mem #(
  parameter int SEED = 1,
  parameter int DLY  = 1
) (
  input  logic        clk,
  input  logic        rd_valid_i,
  input  logic [31:0] rd_addr_i,
  output logic        rd_ready_o,
  output logic [63:0] rd_data_o,
  input  logic        wr_valid_i,
  input  logic [31:0] wr_addr_i,
  input  logic [63:0] wr_data_i,
  output logic        wr_ready_o,
  input  logic [31:0] peek_addr_i,
  output logic [63:0] peek_data_o
);

  logic [7:0] bytes [65536];  // low 64 KB of the address space
  int seed = SEED;
  int rd_cnt = 0;
  int wr_cnt = 0;

  function automatic logic [63:0] dw_at(input logic [31:0] a);
    logic [63:0] v;
    for (int i = 0; i < 8; i++)
      v[8*i +: 8] = bytes[int'(a[15:0]) + i];
    return v;
  endfunction

  initial begin
    logic [63:0] fill;
    rd_ready_o = 1'b0;
    wr_ready_o = 1'b0;
    rd_data_o  = '0;
    for (int a = 0; a < 65536; a += 8) begin
      fill = {32'(a) ^ 32'ha5c3_0f00, ~32'(a)};
      for (int i = 0; i < 8; i++)
        bytes[a + i] = fill[8*i +: 8];
    end
  end

  // beats move at the coming edge, so the counters step mid-cycle
  always @(negedge clk) begin
    if (wr_valid_i && wr_ready_o) begin
      for (int i = 0; i < 8; i++)
        bytes[int'(wr_addr_i[15:0]) + 8 * wr_cnt + i] = wr_data_i[8*i +: 8];
      wr_cnt = (wr_cnt + 1) % 8;
    end
    if (rd_valid_i && rd_ready_o)
      rd_cnt = (rd_cnt + 1) % 8;
  end

  always @(posedge clk) begin
    #(DLY);
    rd_ready_o = ($random(seed) & 3) != 0;  // stall about one beat in four
    wr_ready_o = ($random(seed) & 3) != 0;
    rd_data_o  = dw_at(rd_addr_i + 32'(8 * rd_cnt));
  end

  assign peek_data_o = dw_at(peek_addr_i);

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
  parameter int INDEX_W = DEF_INDEX_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid_i,
  input  logic                req_write_i,
  input  logic [ADDR_W-1:0]   req_addr_i,
  input  logic [DATA_W-1:0]   req_wdata_i,
  input  logic [DATA_W/8-1:0] req_mask_i,
  output logic                ready_o,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                mem_rd_valid_o,
  output logic [ADDR_W-1:0]   mem_rd_addr_o,
  input  logic                mem_rd_ready_i,
  input  logic [DATA_W-1:0]   mem_rd_data_i,
  output logic                mem_wr_valid_o,
  output logic [ADDR_W-1:0]   mem_wr_addr_o,
  output logic [DATA_W-1:0]   mem_wr_data_o,
  input  logic                mem_wr_ready_i
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  dcache_addr_u                     req_addr;
  logic                             hit;
  logic                             victim_dirty;
  logic [TAG_W-1:0]                 stored_tag;
  logic [$clog2(BEATS):0]           beat;
  logic [INDEX_W-1:0]               bank_index;
  logic [BANK_COUNT-1:0]            bank_wen;
  logic [BANK_W-1:0]                bank_wdata;
  logic [BANK_W-1:0]                bank_wmask;
  logic                             tag_wen;
  logic                             tag_dirty;
  logic [BANK_COUNT-1:0][BANK_W-1:0] bank_rdata;

  assign req_addr = req_addr_i;

  dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_write_i    (req_write_i),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata_i),
    .req_mask_i     (req_mask_i),
    .hit_i          (hit),
    .dirty_i        (victim_dirty),
    .stored_tag_i   (stored_tag),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_wr_ready_i (mem_wr_ready_i),
    .ready_o        (ready_o),
    .mem_rd_valid_o (mem_rd_valid_o),
    .mem_rd_addr_o  (mem_rd_addr_o),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_addr_o  (mem_wr_addr_o),
    .beat_o         (beat),
    .bank_index_o   (bank_index),
    .bank_wen_o     (bank_wen),
    .bank_wdata_o   (bank_wdata),
    .bank_wmask_o   (bank_wmask),
    .tag_wen_o      (tag_wen),
    .dirty_o        (tag_dirty)
  );

  dcache_tag_array #(.INDEX_W(INDEX_W)) u_tags (
    .clk          (clk),
    .rst          (rst),
    .index_i      (bank_index),
    .tag_i        (req_addr.raw[ADDR_W-1 -: TAG_W]),
    .wen_i        (tag_wen),
    .dirty_i      (tag_dirty),
    .hit_o        (hit),
    .dirty_o      (victim_dirty),
    .stored_tag_o (stored_tag)
  );

  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    dcache_data_bank #(.INDEX_W(INDEX_W)) u_bank (
      .clk     (clk),
      .index_i (bank_index),
      .wen_i   (bank_wen[b]),
      .wdata_i (bank_wdata),
      .wmask_i (bank_wmask),
      .rdata_o (bank_rdata[b])
    );
  end

  dcache_line_select u_sel (
    .bank_rdata_i (bank_rdata),
    .offset_i     (req_addr.f.offset),
    .beat_i       (beat),
    .cpu_rdata_o  (rdata_o),
    .wb_data_o    (mem_wr_data_o)  // victim beat while the index holds
  );

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
  parameter int INDEX_W = DEF_INDEX_W
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req_valid_i,
  input  logic                               req_write_i,
  input  dcache_addr_u                       req_addr_i,
  input  logic [DATA_W-1:0]                  req_wdata_i,
  input  logic [DATA_W/8-1:0]                req_mask_i,
  input  logic                               hit_i,
  input  logic                               dirty_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0] stored_tag_i,
  input  logic                               mem_rd_ready_i,
  input  logic [DATA_W-1:0]                  mem_rd_data_i,
  input  logic                               mem_wr_ready_i,
  output logic                               ready_o,
  output logic                               mem_rd_valid_o,
  output logic [ADDR_W-1:0]                  mem_rd_addr_o,
  output logic                               mem_wr_valid_o,
  output logic [ADDR_W-1:0]                  mem_wr_addr_o,
  output logic [$clog2(BEATS):0]             beat_o,
  output logic [INDEX_W-1:0]                 bank_index_o,
  output logic [BANK_COUNT-1:0]              bank_wen_o,
  output logic [BANK_W-1:0]                  bank_wdata_o,
  output logic [BANK_W-1:0]                  bank_wmask_o,
  output logic                               tag_wen_o,
  output logic                               dirty_o
);

  localparam int BSEL_W = $clog2(BANK_COUNT);
  localparam int HALF_B = OFFSET_W - BSEL_W - 1;  // doubleword half bit

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_WB     = 2'd1;
  localparam logic [1:0] S_REFILL = 2'd2;

  logic [1:0]         state_q;
  logic               wr_hit_q;  // bank write in the ready cycle
  logic               fill_q;    // tag write after the last refill beat
  logic               accept;
  logic               rd_hs;
  logic               wr_hs;
  logic               last_beat;
  logic [DATA_W-1:0]  byte_bits;
  dcache_addr_u       line_base;

  assign bank_index_o = req_addr_i.raw[OFFSET_W +: INDEX_W];
  assign accept    = (state_q == S_IDLE) && req_valid_i && !ready_o && !fill_q;
  assign rd_hs     = mem_rd_valid_o && mem_rd_ready_i;
  assign wr_hs     = mem_wr_valid_o && mem_wr_ready_i;
  assign last_beat = (beat_o == BEATS - 1);

  always_comb begin
    line_base          = req_addr_i;
    line_base.f.offset = '0;
  end

  always_comb begin
    for (int i = 0; i < DATA_W / 8; i++) begin
      byte_bits[8*i +: 8] = {8{req_mask_i[i]}};  // byte mask to bit mask
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= S_IDLE;
      beat_o         <= '0;
      ready_o        <= 1'b0;
      wr_hit_q       <= 1'b0;
      fill_q         <= 1'b0;
      mem_rd_valid_o <= 1'b0;
      mem_wr_valid_o <= 1'b0;
    end else begin
      ready_o  <= accept && hit_i;
      wr_hit_q <= accept && hit_i && req_write_i;
      fill_q   <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept && !hit_i) begin
            beat_o <= '0;
            if (dirty_i) begin
              state_q        <= S_WB;
              mem_wr_valid_o <= 1'b1;
            end else begin
              state_q        <= S_REFILL;
              mem_rd_valid_o <= 1'b1;
            end
          end
        end
        S_WB: begin
          if (wr_hs) begin
            if (last_beat) begin
              beat_o         <= '0;
              mem_wr_valid_o <= 1'b0;
              mem_rd_valid_o <= 1'b1;  // refill right behind
              state_q        <= S_REFILL;
            end else begin
              beat_o <= beat_o + 1'b1;
            end
          end
        end
        S_REFILL: begin
          if (rd_hs) begin
            if (last_beat) begin
              beat_o         <= '0;
              mem_rd_valid_o <= 1'b0;
              fill_q         <= 1'b1;
              state_q        <= S_IDLE;  // lookup again, hits
            end else begin
              beat_o <= beat_o + 1'b1;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !hit_i) begin
      mem_wr_addr_o <= {stored_tag_i, bank_index_o, {OFFSET_W{1'b0}}};  // victim line
      mem_rd_addr_o <= line_base.raw;
    end
  end

  // bank write steering
  always_comb begin
    bank_wen_o = '0;
    if (wr_hit_q) begin
      bank_wen_o[req_addr_i.f.offset[OFFSET_W-1 -: BSEL_W]] = 1'b1;
      bank_wdata_o = {2{req_wdata_i}};
      bank_wmask_o = req_addr_i.f.offset[HALF_B] ? {byte_bits, {DATA_W{1'b0}}}
                                                 : {{DATA_W{1'b0}}, byte_bits};
    end else begin
      bank_wen_o[beat_o[BSEL_W:1]] = rd_hs;  // beat k into bank k/2
      bank_wdata_o = {2{mem_rd_data_i}};
      bank_wmask_o = beat_o[0] ? {{DATA_W{1'b1}}, {DATA_W{1'b0}}}
                               : {{DATA_W{1'b0}}, {DATA_W{1'b1}}};
    end
  end

  assign tag_wen_o = wr_hit_q || fill_q;
  assign dirty_o   = wr_hit_q;  // refill leaves the line clean

  a_one_burst: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_valid_o && mem_wr_valid_o));

  a_beat_range: assert property (@(posedge clk) disable iff (rst) beat_o < BEATS);

endmodule

`default_nettype wire

/* design/dcache_line_select.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_line_select import dcache_pkg::*; (
  input  logic [BANK_COUNT-1:0][BANK_W-1:0] bank_rdata_i,
  input  logic [OFFSET_W-1:0]               offset_i,
  input  logic [$clog2(BEATS):0]            beat_i,
  output logic [DATA_W-1:0]                 cpu_rdata_o,
  output logic [DATA_W-1:0]                 wb_data_o
);

  localparam int BSEL_W = $clog2(BANK_COUNT);

  logic [BANK_W-1:0] cpu_word;
  logic [BANK_W-1:0] wb_word;

  // cpu side keyed by address offset
  assign cpu_word    = bank_rdata_i[offset_i[OFFSET_W-1 -: BSEL_W]];
  assign cpu_rdata_o = offset_i[OFFSET_W-BSEL_W-1] ? cpu_word[BANK_W-1 -: DATA_W]
                                                   : cpu_word[DATA_W-1:0];

  // write-back side keyed by burst beat
  assign wb_word   = bank_rdata_i[beat_i[BSEL_W:1]];
  assign wb_data_o = beat_i[0] ? wb_word[BANK_W-1 -: DATA_W] : wb_word[DATA_W-1:0];

endmodule

`default_nettype wire

/* design/dcache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array import dcache_pkg::*; #(
  parameter int INDEX_W = DEF_INDEX_W
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [INDEX_W-1:0]                  index_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  tag_i,
  input  logic                                wen_i,
  input  logic                                dirty_i,
  output logic                                hit_o,
  output logic                                dirty_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  stored_tag_o
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINES = 1 << INDEX_W;

  logic [TAG_W-1:0] tags_q [LINES];
  logic [LINES-1:0] valid_q;
  logic [LINES-1:0] dirty_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wen_i) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= dirty_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wen_i) begin
      tags_q[index_i] <= tag_i;
    end
  end

  // lookup is combinational
  assign stored_tag_o = tags_q[index_i];
  assign hit_o        = valid_q[index_i] && (tags_q[index_i] == tag_i);
  assign dirty_o      = valid_q[index_i] && dirty_q[index_i];  // invalid line is never a victim

endmodule

`default_nettype wire

/* design/dcache_data_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_bank import dcache_pkg::*; #(
  parameter int INDEX_W = DEF_INDEX_W
) (
  input  logic               clk,
  input  logic [INDEX_W-1:0] index_i,
  input  logic               wen_i,
  input  logic [BANK_W-1:0]  wdata_i,
  input  logic [BANK_W-1:0]  wmask_i,
  output logic [BANK_W-1:0]  rdata_o
);

  localparam int LINES = 1 << INDEX_W;

  logic [BANK_W-1:0] mem_q [LINES];

  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem_q[index_i] <= (mem_q[index_i] & ~wmask_i) | (wdata_i & wmask_i);  // bit-masked merge
    end
    rdata_o <= mem_q[index_i];  // read every cycle
  end

  // the controller never strobes a bank without selecting some bits
  a_wmask_nonzero: assert property (@(posedge clk) wen_i |-> (|wmask_i));

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 64;   // cpu and memory word
  localparam int OFFSET_W    = 6;    // 64-byte lines
  localparam int BANK_COUNT  = 4;
  localparam int BANK_W      = 128;  // two doublewords per bank entry
  localparam int BEATS       = 8;    // doublewords per line burst
  localparam int DEF_INDEX_W = 6;    // 64 lines

  // one address word, seen raw on the memory side or split for lookup
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [ADDR_W-DEF_INDEX_W-OFFSET_W-1:0] tag;
      logic [DEF_INDEX_W-1:0]                 index;
      logic [OFFSET_W-1:0]                    offset;
    } f;
  } dcache_addr_u;

endpackage

`default_nettype wire
